// File: dv/sprite_motion_tb.sv
// Table-driven testbench for the sprite motion core with a cycle model; compiled through tb.f.
`timescale 1ns/1ps

module sprite_motion_tb
    import sprite_geom_pkg::*;
    import motion_pkg::*;
();

    localparam int START_X           = 100;
    localparam int TIME_START_X      = 8;
    localparam int TIME_STEP_X       = 2;
    localparam int TIME_MIN_X        = 4;
    localparam int TIME_START_Y      = 2;
    localparam int TIME_STEP_Y       = 1;
    localparam int TIME_MAX_Y        = 6;
    localparam int TIME_TERM_Y       = 4;
    localparam int BEGIN_COUNT_EXTRA = 4;
    localparam int MAX_STEPS         = 40;

    typedef enum int
    {
        k_none, k_reset, k_dir, k_x_stable, k_x_min, k_x_max, k_jump, k_land, k_peak
    } check_t;

    typedef struct
    {
        int     test;
        logic   up;
        logic   left;
        logic   right;
        logic   gnd;
        int     hold;
        check_t kind;
        int     exp;
    } step_t;

    logic   clk;
    logic   reset;
    logic   btn_up;
    logic   btn_left;
    logic   btn_right;
    logic   grounded;
    coord_t pos_x;
    coord_t pos_y;
    dir_t   direction;
    logic   jumping_up;

    step_t steps[MAX_STEPS];
    string test_names[8];
    int    n_steps, limit, cycles, errors, test_errs, tests_run, tests_failed;

    // reference model state.
    x_state_t              mx_state;
    int                    mx_timer, mx_int, mx_pos, mx_dir;
    y_state_t              my_state;
    int                    my_timer, my_int, my_extra, my_pos;
    logic [EDGE_DEPTH-1:0] my_hist;

    // trackers for the running test and step.
    int   test_y0, min_y, m_min_y, tapped_rise, step_x, step_y, step_my, prev_y;
    logic saw_jump, prev_jump;

    sprite_motion #(
        .START_X           (START_X),
        .TIME_START_X      (TIME_START_X),
        .TIME_STEP_X       (TIME_STEP_X),
        .TIME_MIN_X        (TIME_MIN_X),
        .TIME_START_Y      (TIME_START_Y),
        .TIME_STEP_Y       (TIME_STEP_Y),
        .TIME_MAX_Y        (TIME_MAX_Y),
        .TIME_TERM_Y       (TIME_TERM_Y),
        .BEGIN_COUNT_EXTRA (BEGIN_COUNT_EXTRA)
    ) u_dut (
        .clk        (clk),
        .reset      (reset),
        .btn_up     (btn_up),
        .btn_left   (btn_left),
        .btn_right  (btn_right),
        .grounded   (grounded),
        .pos_x      (pos_x),
        .pos_y      (pos_y),
        .direction  (direction),
        .jumping_up (jumping_up)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic add_step(input int test, input logic up, input logic left, input logic right,
                            input logic gnd, input int hold, input check_t kind, input int exp);
        steps[n_steps].test  = test;
        steps[n_steps].up    = up;
        steps[n_steps].left  = left;
        steps[n_steps].right = right;
        steps[n_steps].gnd   = gnd;
        steps[n_steps].hold  = hold;
        steps[n_steps].kind  = kind;
        steps[n_steps].exp   = exp;
        n_steps++;
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("mismatch %s at cycle %0d: got 0x%0h, expected 0x%0h",
                     name, cycles, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic report_fault(input string what);
        $display("error at cycle %0d: %s", cycles, what);
        errors++;
        test_errs++;
    endtask

    // --------------------
    // reference model
    // --------------------
    task automatic model_x();
        x_state_t ns;
        int       nt, ni, np;
        logic     lone, rone, fwd, rev;
        ns = mx_state;
        nt = mx_timer;
        ni = mx_int;
        np = mx_pos;
        lone = btn_left && !btn_right;
        rone = btn_right && !btn_left;
        if (mx_state == x_idle)
        begin
            if (rone && mx_pos < MAX_X)
            begin
                ns = x_right;
                nt = TIME_START_X;
                ni = TIME_START_X;
            end
            else if (lone && mx_pos >= 1)
            begin
                ns = x_left;
                nt = TIME_START_X;
                ni = TIME_START_X;
            end
        end
        else
        begin
            fwd = (mx_state == x_right) ? btn_right : btn_left;
            rev = (mx_state == x_right) ? btn_left : btn_right;
            if (mx_timer > 0)
                nt = mx_timer - 1;
            else
            begin
                if (mx_state == x_right)
                    np = (mx_pos < MAX_X) ? mx_pos + 1 : mx_pos;
                else
                    np = (mx_pos > MIN_X) ? mx_pos - 1 : mx_pos;
                if (fwd && mx_int > TIME_MIN_X)
                    ni = mx_int - TIME_STEP_X;
                else if (rev && mx_int < TIME_START_X)
                    ni = mx_int + TIME_STEP_X;
                nt = ni;
            end
            if (grounded && (!fwd || (btn_left && btn_right)))
                ns = x_idle;
            else if (!grounded && rev && mx_int >= TIME_START_X)
            begin
                ns = (mx_state == x_right) ? x_left : x_right;
                nt = TIME_START_X;
                ni = TIME_START_X;
            end
        end
        if (lone)
            mx_dir = 0;
        else if (rone)
            mx_dir = 1;
        mx_state = ns;
        mx_timer = nt;
        mx_int   = ni;
        mx_pos   = np;
    endtask

    task automatic model_y();
        y_state_t ns;
        int       nt, ni, ne, np;
        logic     up_edge, one;
        ns = my_state;
        nt = my_timer;
        ni = my_int;
        ne = my_extra;
        np = my_pos;
        up_edge = btn_up && (my_hist != '1);
        one = btn_left ^ btn_right;
        case (my_state)
            y_standing, y_walking:
            begin
                if (my_state == y_standing && one)
                    ns = y_walking;
                if (my_state == y_walking && !grounded)
                begin
                    ns = y_jump_down;
                    ni = TIME_MAX_Y;
                    nt = TIME_MAX_Y;
                end
                if (my_state == y_walking && !one)
                    ns = y_standing;
                if (up_edge)
                begin
                    ns = y_jump_up;
                    ni = TIME_START_Y;
                    nt = TIME_START_Y;
                    ne = 0;
                end
            end
            y_jump_up:
            begin
                if (my_timer > 0)
                    nt = my_timer - 1;
                else
                begin
                    if (btn_up && my_int > BEGIN_COUNT_EXTRA)
                        ne = my_extra + 1;
                    if (my_pos > MIN_Y)
                        np = my_pos - 1;
                    else
                        ns = y_jump_down;
                    if (my_int <= TIME_MAX_Y)
                    begin
                        ni = my_int + TIME_STEP_Y;
                        nt = ni;
                    end
                    else
                    begin
                        // doubles the count held before this tick.
                        ns = y_jump_extra;
                        ne = 2 * my_extra;
                        ni = TIME_MAX_Y;
                        nt = TIME_MAX_Y;
                    end
                end
            end
            y_jump_extra:
            begin
                if (my_extra == 0)
                begin
                    ns = y_jump_down;
                    ni = TIME_MAX_Y;
                    nt = TIME_MAX_Y;
                end
                else if (my_timer > 0)
                    nt = my_timer - 1;
                else
                begin
                    ne = my_extra - 1;
                    if (my_pos > MIN_Y)
                        np = my_pos - 1;
                    else
                        ns = y_jump_down;
                    ni = TIME_MAX_Y;
                    nt = TIME_MAX_Y;
                end
            end
            default:
            begin
                if (my_timer > 0)
                    nt = my_timer - 1;
                else if (!grounded)
                begin
                    np = my_pos + 1;
                    if (my_int > TIME_TERM_Y)
                    begin
                        ni = my_int - TIME_STEP_Y;
                        nt = ni;
                    end
                    else
                        nt = TIME_TERM_Y;
                end
                else
                    ns = y_standing;
            end
        endcase
        my_hist  = {my_hist[EDGE_DEPTH-2:0], btn_up};
        my_state = ns;
        my_timer = nt;
        my_int   = ni;
        my_extra = ne;
        my_pos   = np;
    endtask

    // --------------------
    // checks
    // --------------------
    task automatic compare_model();
        check_value("pos_x", int'(pos_x), mx_pos);
        check_value("pos_y", int'(pos_y), my_pos);
        check_value("direction", int'(direction), mx_dir);
        check_value("jumping_up", int'(jumping_up), (my_state == y_jump_up) ? 1 : 0);
        if (int'(pos_y) < min_y)
            min_y = int'(pos_y);
        if (my_pos < m_min_y)
            m_min_y = my_pos;
        if (jumping_up)
            saw_jump = 1'b1;
    endtask

    task automatic cycle_checks(input check_t kind);
        case (kind)
            k_x_stable:
                check_value("pos_x", int'(pos_x), step_x);
            k_x_min:
                if (int'(pos_x) < MIN_X)
                    report_fault("pos_x moved past the left wall");
            k_x_max:
                if (int'(pos_x) > MAX_X)
                    report_fault("pos_x moved past the right wall");
            k_jump:
                if (prev_jump && int'(pos_y) > prev_y)
                    report_fault("pos_y moved down while jumping_up was high");
            k_land:
            begin
                check_value("pos_y", int'(pos_y), step_y);
                check_value("jumping_up", int'(jumping_up), 0);
            end
            default:
                ;
        endcase
        prev_y    = int'(pos_y);
        prev_jump = jumping_up;
    endtask

    task automatic end_checks(input step_t st);
        int rise;
        // height gained by this step's jump, measured from where it started.
        rise = step_y - min_y;
        case (st.kind)
            k_reset:
            begin
                check_value("pos_x", int'(pos_x), START_X);
                check_value("pos_y", int'(pos_y), START_Y);
                check_value("direction", int'(direction), 1);
                check_value("jumping_up", int'(jumping_up), 0);
            end
            k_dir:
                check_value("direction", int'(direction), st.exp);
            k_x_min:
                check_value("pos_x", int'(pos_x), MIN_X);
            k_x_max:
                check_value("pos_x", int'(pos_x), MAX_X);
            k_jump:
            begin
                if (!saw_jump)
                    report_fault("jumping_up never rose after the up press");
                check_value("jumping_up", int'(jumping_up), 0);
                if (int'(pos_y) <= min_y)
                    report_fault("pos_y did not come down after the peak");
            end
            k_peak:
            begin
                check_value("pos_y peak", min_y, m_min_y);
                check_value("jump rise", rise, step_my - m_min_y);
                if (st.exp == 0)
                    tapped_rise = rise;
                else if (rise <= tapped_rise)
                    report_fault("held jump rose no higher than the tapped jump");
            end
            default:
                ;
        endcase
    endtask

    task automatic run_step(input step_t st);
        btn_up    = st.up;
        btn_left  = st.left;
        btn_right = st.right;
        grounded  = st.gnd;
        step_x    = int'(pos_x);
        step_y    = int'(pos_y);
        step_my   = my_pos;
        prev_y    = step_y;
        prev_jump = jumping_up;
        repeat (st.hold)
        begin
            @(posedge clk);
            model_x();
            model_y();
            #1;
            compare_model();
            cycle_checks(st.kind);
        end
        end_checks(st);
    endtask

    task automatic build_table();
        test_names[1] = "reset values";
        test_names[2] = "facing register";
        test_names[3] = "walk right with momentum";
        test_names[4] = "wall limits";
        test_names[5] = "jump and fall";
        test_names[6] = "tapped and held jumps";
        test_names[7] = "random walk jitter";
        add_step(1, 1'b0, 1'b0, 1'b0, 1'b1, 1, k_reset, 0);
        add_step(2, 1'b0, 1'b1, 1'b0, 1'b1, 1, k_dir, 0);
        add_step(2, 1'b0, 1'b1, 1'b1, 1'b1, 3, k_dir, 0);
        add_step(2, 1'b0, 1'b0, 1'b1, 1'b1, 1, k_dir, 1);
        add_step(2, 1'b0, 1'b0, 1'b0, 1'b1, 2, k_dir, 1);
        add_step(3, 1'b0, 1'b0, 1'b1, 1'b1, 60, k_none, 0);
        add_step(3, 1'b0, 1'b0, 1'b0, 1'b1, 1, k_none, 0);
        add_step(3, 1'b0, 1'b0, 1'b0, 1'b1, 20, k_x_stable, 0);
        add_step(4, 1'b0, 1'b1, 1'b0, 1'b1, 600, k_x_min, 0);
        add_step(4, 1'b0, 1'b0, 1'b0, 1'b1, 1, k_none, 0);
        add_step(4, 1'b0, 1'b0, 1'b1, 1'b1, 3100, k_x_max, 0);
        add_step(4, 1'b0, 1'b0, 1'b0, 1'b1, 1, k_none, 0);
        add_step(5, 1'b1, 1'b0, 1'b0, 1'b0, 1, k_none, 0);
        add_step(5, 1'b0, 1'b0, 1'b0, 1'b0, 100, k_jump, 0);
        add_step(5, 1'b0, 1'b0, 1'b0, 1'b1, 20, k_land, 0);
        add_step(6, 1'b1, 1'b0, 1'b0, 1'b1, 1, k_none, 0);
        add_step(6, 1'b0, 1'b0, 1'b0, 1'b1, 60, k_peak, 0);
        add_step(6, 1'b1, 1'b0, 1'b0, 1'b1, 90, k_peak, 1);
        add_step(6, 1'b0, 1'b0, 1'b0, 1'b1, 5, k_none, 0);
        // left, right and both in turn, each for a random length.
        for (int i = 0; i < 10; i++)
            add_step(7, 1'b0, (i % 3) != 1, (i % 3) != 0, 1'b1,
                     1 + int'($urandom % 12), k_none, 0);
        add_step(7, 1'b0, 1'b0, 1'b1, 1'b1, 1 + int'($urandom % 12), k_dir, 1);
    endtask

    initial
    begin
        int total;
        clk       = 1'b0;
        reset     = 1'b1;
        btn_up    = 1'b0;
        btn_left  = 1'b0;
        btn_right = 1'b0;
        grounded  = 1'b1;
        {cycles, limit, errors, n_steps, tests_run, tests_failed, tapped_rise} = '0;
        void'($urandom(37));
        build_table();
        total = 0;
        for (int i = 0; i < n_steps; i++)
            total += steps[i].hold;
        limit = 2 * total + 100;

        mx_state = x_idle;
        {mx_timer, mx_int, my_timer, my_int, my_extra} = '0;
        mx_pos   = START_X;
        mx_dir   = 1;
        my_state = y_standing;
        my_pos   = START_Y;
        my_hist  = '0;

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < n_steps; i++)
        begin
            if (i == 0 || steps[i].test != steps[i-1].test)
            begin
                test_errs = 0;
                test_y0   = int'(pos_y);
                min_y     = test_y0;
                m_min_y   = my_pos;
                saw_jump  = 1'b0;
            end
            run_step(steps[i]);
            if (i == n_steps - 1 || steps[i+1].test != steps[i].test)
            begin
                tests_run++;
                if (test_errs != 0)
                    tests_failed++;
                $display("test %0d, %s: %s", steps[i].test, test_names[steps[i].test],
                         (test_errs == 0) ? "ok" : "FAILED");
            end
        end

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the sprite motion testbench with Verilator, run it and check the log.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! verilator --binary --timing --assert -j 0 \
        --top-module sprite_motion_tb \
        -Mdir "$build_dir" -o sim \
        -f tb.f; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test failures found" "$log_file"; then
    echo "result: FAIL"
    exit 1
fi

echo "result: PASS"
exit 0

// File: src/motion_pkg.sv
// State encodings, facing type and timer widths, imported by the x and y motion machines.
package motion_pkg;

    // --------------------
    // facing
    // --------------------
    typedef enum logic
    {
        dir_left  = 1'b0,
        dir_right = 1'b1
    } dir_t;

    // --------------------
    // machine states
    // --------------------
    typedef enum logic [1:0]
    {
        x_idle  = 2'b00,
        x_left  = 2'b01,
        x_right = 2'b10
    } x_state_t;

    typedef enum logic [2:0]
    {
        y_standing   = 3'b000,
        y_walking    = 3'b001,
        y_jump_up    = 3'b010,
        y_jump_extra = 3'b011,
        y_jump_down  = 3'b100
    } y_state_t;

    // interval timers hold tick counts up to about one million.
    localparam int TIMER_W    = 20;
    localparam int EXTRA_W    = 26;
    localparam int EDGE_DEPTH = 8;

endpackage

// File: src/sprite_geom_pkg.sv
// Screen, tile and coordinate definitions, imported by the motion modules and the top level.
package sprite_geom_pkg;

    // one screen coordinate, wide enough for 640 x 480.
    typedef logic [9:0] coord_t;

    // --------------------
    // screen and tile
    // --------------------
    localparam int SCREEN_W = 640;
    localparam int SCREEN_H = 480;
    localparam int TILE     = 16;

    // the head sits this far right of the torso when facing right.
    localparam int HEAD_OFFSET = 9;

    // --------------------
    // movement limits
    // --------------------
    // top edge may not rise above the ceiling tile.
    localparam int MIN_Y   = 16;
    // character stands two tiles above the floor strip.
    localparam int START_Y = SCREEN_H - 2 * TILE - 16;

    // walls on both sides are one tile thick.
    localparam int MIN_X = 16;
    localparam int MAX_X = SCREEN_W - TILE - HEAD_OFFSET - 16;

endpackage

// File: src/sprite_motion.sv
// Motion core top level; owns the timing parameters and connects the x and y machines.
`timescale 1ns/1ps

module sprite_motion
    import sprite_geom_pkg::*;
    import motion_pkg::*;
#(
    parameter int START_X           = 100,
    parameter int TIME_START_X      = 800000,
    parameter int TIME_STEP_X       = 6000,
    parameter int TIME_MIN_X        = 500000,
    parameter int TIME_START_Y      = 100000,
    parameter int TIME_STEP_Y       = 8000,
    parameter int TIME_MAX_Y        = 600000,
    parameter int TIME_TERM_Y       = 250000,
    parameter int BEGIN_COUNT_EXTRA = 450000
)
(
    input  logic   clk,
    input  logic   reset,
    input  logic   btn_up,
    input  logic   btn_left,
    input  logic   btn_right,
    input  logic   grounded,
    output coord_t pos_x,
    output coord_t pos_y,
    output dir_t   direction,
    output logic   jumping_up
);

    // horizontal motion and facing.
    x_motion #(
        .START_X      (START_X),
        .TIME_START_X (TIME_START_X),
        .TIME_STEP_X  (TIME_STEP_X),
        .TIME_MIN_X   (TIME_MIN_X)
    ) u_x_motion (
        .clk       (clk),
        .reset     (reset),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .grounded  (grounded),
        .pos_x     (pos_x),
        .direction (direction)
    );

    // vertical walk, jump and fall.
    y_motion #(
        .TIME_START_Y      (TIME_START_Y),
        .TIME_STEP_Y       (TIME_STEP_Y),
        .TIME_MAX_Y        (TIME_MAX_Y),
        .TIME_TERM_Y       (TIME_TERM_Y),
        .BEGIN_COUNT_EXTRA (BEGIN_COUNT_EXTRA)
    ) u_y_motion (
        .clk        (clk),
        .reset      (reset),
        .btn_up     (btn_up),
        .btn_left   (btn_left),
        .btn_right  (btn_right),
        .grounded   (grounded),
        .pos_y      (pos_y),
        .jumping_up (jumping_up)
    );

endmodule

// File: src/x_motion.sv
// Facing register and horizontal momentum machine; instantiated once by the sprite motion top.
`timescale 1ns/1ps

module x_motion
    import sprite_geom_pkg::*;
    import motion_pkg::*;
#(
    parameter int START_X      = 100,
    parameter int TIME_START_X = 800000,
    parameter int TIME_STEP_X  = 6000,
    parameter int TIME_MIN_X   = 500000
)
(
    input  logic   clk,
    input  logic   reset,
    input  logic   btn_left,
    input  logic   btn_right,
    input  logic   grounded,
    output coord_t pos_x,
    output dir_t   direction
);

    localparam logic [TIMER_W-1:0] T_START = TIMER_W'(TIME_START_X);
    localparam logic [TIMER_W-1:0] T_STEP  = TIMER_W'(TIME_STEP_X);
    localparam logic [TIMER_W-1:0] T_MIN   = TIMER_W'(TIME_MIN_X);
    localparam coord_t X_LO = coord_t'(MIN_X);
    localparam coord_t X_HI = coord_t'(MAX_X);

    logic left_only;
    logic right_only;
    logic both_btn;

    assign left_only  = btn_left && !btn_right;
    assign right_only = btn_right && !btn_left;
    assign both_btn   = btn_left && btn_right;

    // --------------------
    // facing
    // --------------------
    dir_t dir_reg;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            dir_reg <= dir_right;
        else if (left_only)
            dir_reg <= dir_left;
        else if (right_only)
            dir_reg <= dir_right;
    end

    assign direction = dir_reg;

    // --------------------
    // momentum FSM
    // --------------------
    x_state_t           state_reg, state_next;
    logic [TIMER_W-1:0] timer_reg, timer_next;
    logic [TIMER_W-1:0] interval_reg, interval_next;
    coord_t             pos_reg, pos_next;

    logic moving_right;
    logic fwd_btn;
    logic rev_btn;

    // forward is the button matching the current motion.
    assign moving_right = (state_reg == x_right);
    assign fwd_btn      = moving_right ? btn_right : btn_left;
    assign rev_btn      = moving_right ? btn_left : btn_right;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state_reg    <= x_idle;
            timer_reg    <= '0;
            interval_reg <= '0;
            pos_reg      <= coord_t'(START_X);
        end
        else
        begin
            state_reg    <= state_next;
            timer_reg    <= timer_next;
            interval_reg <= interval_next;
            pos_reg      <= pos_next;
        end
    end

    always_comb
    begin
        state_next    = state_reg;
        timer_next    = timer_reg;
        interval_next = interval_reg;
        pos_next      = pos_reg;

        case (state_reg)
            x_idle:
            begin
                if (left_only && pos_reg != '0)
                begin
                    state_next    = x_left;
                    timer_next    = T_START;
                    interval_next = T_START;
                end
                else if (right_only && pos_reg < X_HI)
                begin
                    state_next    = x_right;
                    timer_next    = T_START;
                    interval_next = T_START;
                end
            end

            x_left, x_right:
            begin
                if (timer_reg != '0)
                    timer_next = timer_reg - TIMER_W'(1);
                else
                begin
                    if (moving_right && pos_reg < X_HI)
                        pos_next = pos_reg + coord_t'(1);
                    else if (!moving_right && pos_reg > X_LO)
                        pos_next = pos_reg - coord_t'(1);

                    // holding forward speeds up, holding reverse brakes.
                    if (fwd_btn && interval_reg > T_MIN)
                        interval_next = interval_reg - T_STEP;
                    else if (rev_btn && interval_reg < T_START)
                        interval_next = interval_reg + T_STEP;
                    timer_next = interval_next;
                end

                if (grounded && (!fwd_btn || both_btn))
                    state_next = x_idle;
                else if (!grounded && rev_btn && interval_reg >= T_START)
                begin
                    // turn around in the air once fully braked.
                    state_next    = moving_right ? x_left : x_right;
                    timer_next    = T_START;
                    interval_next = T_START;
                end
            end

            default:
                state_next = x_idle;
        endcase
    end

    assign pos_x = pos_reg;

    a_pos_x_max: assert property (@(posedge clk) disable iff (reset) pos_reg <= X_HI);

    a_dir_hold: assert property (@(posedge clk) disable iff (reset)
        both_btn |=> $stable(direction));

endmodule

// File: src/y_motion.sv
// Up-button edge detector and vertical walk, jump and fall machine; instantiated by the top.
`timescale 1ns/1ps

module y_motion
    import sprite_geom_pkg::*;
    import motion_pkg::*;
#(
    parameter int TIME_START_Y      = 100000,
    parameter int TIME_STEP_Y       = 8000,
    parameter int TIME_MAX_Y        = 600000,
    parameter int TIME_TERM_Y       = 250000,
    parameter int BEGIN_COUNT_EXTRA = 450000
)
(
    input  logic   clk,
    input  logic   reset,
    input  logic   btn_up,
    input  logic   btn_left,
    input  logic   btn_right,
    input  logic   grounded,
    output coord_t pos_y,
    output logic   jumping_up
);

    localparam logic [TIMER_W-1:0] T_START = TIMER_W'(TIME_START_Y);
    localparam logic [TIMER_W-1:0] T_STEP  = TIMER_W'(TIME_STEP_Y);
    localparam logic [TIMER_W-1:0] T_MAX   = TIMER_W'(TIME_MAX_Y);
    localparam logic [TIMER_W-1:0] T_TERM  = TIMER_W'(TIME_TERM_Y);
    localparam logic [TIMER_W-1:0] T_EXTRA = TIMER_W'(BEGIN_COUNT_EXTRA);
    localparam coord_t Y_LO = coord_t'(MIN_Y);

    // --------------------
    // up edge
    // --------------------
    logic [EDGE_DEPTH-1:0] up_hist;
    logic                  up_edge;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            up_hist <= '0;
        else
            up_hist <= {up_hist[EDGE_DEPTH-2:0], btn_up};
    end

    // a press counts only after a low somewhere in the recent history.
    assign up_edge = btn_up && !(&up_hist);

    // --------------------
    // vertical FSM
    // --------------------
    y_state_t           state_reg, state_next;
    logic [TIMER_W-1:0] timer_reg, timer_next;
    logic [TIMER_W-1:0] interval_reg, interval_next;
    logic [EXTRA_W-1:0] extra_reg, extra_next;
    coord_t             pos_reg, pos_next;

    logic one_btn;

    assign one_btn = btn_left ^ btn_right;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state_reg    <= y_standing;
            timer_reg    <= '0;
            interval_reg <= '0;
            extra_reg    <= '0;
            pos_reg      <= coord_t'(START_Y);
        end
        else
        begin
            state_reg    <= state_next;
            timer_reg    <= timer_next;
            interval_reg <= interval_next;
            extra_reg    <= extra_next;
            pos_reg      <= pos_next;
        end
    end

    always_comb
    begin
        state_next    = state_reg;
        timer_next    = timer_reg;
        interval_next = interval_reg;
        extra_next    = extra_reg;
        pos_next      = pos_reg;

        case (state_reg)
            y_standing:
            begin
                if (one_btn)
                    state_next = y_walking;
                if (up_edge)
                begin
                    state_next    = y_jump_up;
                    interval_next = T_START;
                    timer_next    = T_START;
                    extra_next    = '0;
                end
            end

            y_walking:
            begin
                // walked off a ledge.
                if (!grounded)
                begin
                    state_next    = y_jump_down;
                    interval_next = T_MAX;
                    timer_next    = T_MAX;
                end
                if (!one_btn)
                    state_next = y_standing;
                if (up_edge)
                begin
                    state_next    = y_jump_up;
                    interval_next = T_START;
                    timer_next    = T_START;
                    extra_next    = '0;
                end
            end

            y_jump_up:
            begin
                if (timer_reg != '0)
                    timer_next = timer_reg - TIMER_W'(1);
                else
                begin
                    // up held late in the climb banks extra height.
                    if (btn_up && interval_reg > T_EXTRA)
                        extra_next = extra_reg + EXTRA_W'(1);

                    if (pos_reg > Y_LO)
                        pos_next = pos_reg - coord_t'(1);
                    else
                        state_next = y_jump_down;

                    // the climb slows each pixel until it hits the slowest rate.
                    if (interval_reg <= T_MAX)
                    begin
                        interval_next = interval_reg + T_STEP;
                        timer_next    = interval_reg + T_STEP;
                    end
                    else
                    begin
                        state_next    = y_jump_extra;
                        extra_next    = extra_reg << 1;
                        interval_next = T_MAX;
                        timer_next    = T_MAX;
                    end
                end
            end

            y_jump_extra:
            begin
                if (extra_reg == '0)
                begin
                    state_next    = y_jump_down;
                    interval_next = T_MAX;
                    timer_next    = T_MAX;
                end
                else if (timer_reg != '0)
                    timer_next = timer_reg - TIMER_W'(1);
                else
                begin
                    extra_next = extra_reg - EXTRA_W'(1);
                    if (pos_reg > Y_LO)
                        pos_next = pos_reg - coord_t'(1);
                    else
                        state_next = y_jump_down;
                    interval_next = T_MAX;
                    timer_next    = T_MAX;
                end
            end

            y_jump_down:
            begin
                if (timer_reg != '0)
                    timer_next = timer_reg - TIMER_W'(1);
                else if (!grounded)
                begin
                    pos_next = pos_reg + coord_t'(1);
                    // fall speeds up to a terminal rate.
                    if (interval_reg > T_TERM)
                    begin
                        interval_next = interval_reg - T_STEP;
                        timer_next    = interval_reg - T_STEP;
                    end
                    else
                        timer_next = T_TERM;
                end
                else
                    state_next = y_standing;
            end

            default:
                state_next = y_standing;
        endcase
    end

    assign pos_y      = pos_reg;
    assign jumping_up = (state_reg == y_jump_up);

    a_pos_y_min: assert property (@(posedge clk) disable iff (reset) pos_reg >= Y_LO);

    a_extra_entry: assert property (@(posedge clk) disable iff (reset)
        $rose(state_reg == y_jump_extra) |-> $past(state_reg) == y_jump_up);

endmodule

// File: tb.f
src/sprite_geom_pkg.sv
src/motion_pkg.sv
src/x_motion.sv
src/y_motion.sv
src/sprite_motion.sv
dv/sprite_motion_tb.sv
